// File: Bender.yml
package:
  name: exec_unit

export_include_dirs:
  - common

sources:
  # Packages first, then leaf modules up to the top level.
  - include_dirs:
      - common
    files:
      - common/exec_types_pkg.sv
      - common/exec_ctrl_pkg.sv
      - alu/divu_remu.sv
      - alu/alu.sv
      - source/exec_issue.sv
      - source/exec_unit.sv

  - target: test
    include_dirs:
      - common
    files:
      - verification/tb_exec_unit.sv

// File: alu/alu.sv
`include "exec_defines.svh"

module alu (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   order,
    input  exec_types_pkg::func3_t func3,
    input  logic                   mode_flag,
    input  logic                   imm_flag,
    input  logic                   extention_flag,
    input  exec_types_pkg::word_t  rs1,
    input  exec_types_pkg::word_t  rs2,
    output logic                   accepted,
    output logic                   done,
    output exec_types_pkg::word_t  rd
);

    logic                  busy_q;
    logic                  order_able;
    logic                  is_div;
    logic                  div_order;
    logic                  div_accepted;
    logic                  div_done;
    exec_types_pkg::word_t div_rd;
    logic                  internal_order;
    exec_types_pkg::word_t internal_rd;
    exec_types_pkg::shamt_t shamt;
    exec_types_pkg::word_t rd_buf_q;
    exec_types_pkg::word_t next_rd;

    // Busy from accept until done.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= ~done & (busy_q | order);
        end
    end

    assign order_able = ~busy_q & order;

    assign is_div = extention_flag &
                    ((func3 == `FUNC3_DIVU) | (func3 == `FUNC3_REMU));

    assign div_order = order_able & is_div;

    divu_remu u_divu_remu (
        .clk      (clk),
        .rst_n    (rst_n),
        .order    (div_order),
        .dividend (rs1),
        .divisor  (rs2),
        .want_rem (func3 == `FUNC3_REMU),
        .accepted (div_accepted),
        .done     (div_done),
        .result   (div_rd)
    );

    // Single cycle operations accept and finish together.
    assign internal_order = order_able & ~is_div;

    assign shamt = rs2[$bits(exec_types_pkg::shamt_t)-1:0];

    always_comb begin
        internal_rd = '0;
        if (!extention_flag) begin
            case (func3)
                `FUNC3_ADD: internal_rd = (mode_flag && !imm_flag) ? rs1 - rs2 : rs1 + rs2;
                `FUNC3_SL:  internal_rd = rs1 << shamt;
                `FUNC3_XOR: internal_rd = rs1 ^ rs2;
                `FUNC3_SR: begin
                    if (mode_flag) begin
                        internal_rd = $signed(rs1) >>> shamt;
                    end else begin
                        internal_rd = rs1 >> shamt;
                    end
                end
                `FUNC3_OR:  internal_rd = rs1 | rs2;
                `FUNC3_AND: internal_rd = rs1 & rs2;
                default:    internal_rd = '0;
            endcase
        end
    end

    assign accepted = div_accepted | internal_order;
    assign done     = div_done | internal_order;

    assign next_rd = div_done       ? div_rd      :
                     internal_order ? internal_rd : rd_buf_q;

    // Keeps rd stable after done.
    always_ff @(posedge clk) begin
        if (done) begin
            rd_buf_q <= next_rd;
        end
    end

    assign rd = next_rd;

endmodule

// File: alu/divu_remu.sv
`include "exec_defines.svh"

module divu_remu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  order,
    input  exec_types_pkg::word_t dividend,
    input  exec_types_pkg::word_t divisor,
    input  logic                  want_rem,
    output logic                  accepted,
    output logic                  done,
    output exec_types_pkg::word_t result
);

    localparam int unsigned CNT_W = $clog2(`DIV_STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`DIV_STEPS - 1);

    exec_ctrl_pkg::div_state_t state_q;
    logic [CNT_W-1:0]          step_cnt_q;
    exec_types_pkg::word_t     rem_q;
    exec_types_pkg::word_t     quot_q;
    exec_types_pkg::word_t     divisor_q;
    logic                      want_rem_q;
    logic [`LEN_WORD:0]        trial;

    assign accepted = order & (state_q == exec_ctrl_pkg::div_idle);
    assign done     = (state_q == exec_ctrl_pkg::div_finish);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= exec_ctrl_pkg::div_idle;
            step_cnt_q <= '0;
        end else begin
            case (state_q)
                exec_ctrl_pkg::div_idle: begin
                    if (accepted) begin
                        state_q    <= exec_ctrl_pkg::div_run;
                        step_cnt_q <= '0;
                    end
                end
                exec_ctrl_pkg::div_run: begin
                    step_cnt_q <= step_cnt_q + 1'b1;
                    if (step_cnt_q == LAST_STEP) begin
                        state_q <= exec_ctrl_pkg::div_finish;
                    end
                end
                exec_ctrl_pkg::div_finish: state_q <= exec_ctrl_pkg::div_idle;
                default: state_q <= exec_ctrl_pkg::div_idle;
            endcase
        end
    end

    // Partial remainder with the next dividend bit, minus the divisor.
    assign trial = {rem_q, quot_q[`LEN_WORD-1]} - {1'b0, divisor_q};

    // Dividend shifts out of quot_q as quotient bits shift in.
    always_ff @(posedge clk) begin
        if (accepted) begin
            rem_q      <= '0;
            quot_q     <= dividend;
            divisor_q  <= divisor;
            want_rem_q <= want_rem;
        end else if (state_q == exec_ctrl_pkg::div_run) begin
            if (!trial[`LEN_WORD]) begin
                rem_q  <= trial[`LEN_WORD-1:0];
                quot_q <= {quot_q[`LEN_WORD-2:0], 1'b1};
            end else begin
                // Restore.
                rem_q  <= {rem_q[`LEN_WORD-2:0], quot_q[`LEN_WORD-1]};
                quot_q <= {quot_q[`LEN_WORD-2:0], 1'b0};
            end
        end
    end

    // Zero divisor never fails the trial, so quotient is all ones.
    assign result = want_rem_q ? rem_q : quot_q;

endmodule

// File: common/exec_ctrl_pkg.sv
package exec_ctrl_pkg;

    typedef enum logic [1:0] {
        issue_idle,
        issue_wait_accept, // Order held high.
        issue_wait_done
    } issue_state_t;

    typedef enum logic [1:0] {
        div_idle,
        div_run,
        div_finish
    } div_state_t;

endpackage

// File: common/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Data path widths.
`define LEN_WORD      32
`define LEN_FUNC3     3
`define LEN_REG_ADDR  5

// Base integer func3 codes.
`define FUNC3_ADD  3'b000
`define FUNC3_SL   3'b001
`define FUNC3_XOR  3'b100
`define FUNC3_SR   3'b101
`define FUNC3_OR   3'b110
`define FUNC3_AND  3'b111

// M extension func3 codes.
`define FUNC3_DIVU 3'b101
`define FUNC3_REMU 3'b111

// Major opcodes.
`define OPCODE_OP     7'b0110011
`define OPCODE_OP_IMM 7'b0010011

// One restoring step per quotient bit.
`define DIV_STEPS 32

`endif

// File: common/exec_types_pkg.sv
`include "exec_defines.svh"

package exec_types_pkg;

    // Operand or result word.
    typedef logic [`LEN_WORD-1:0] word_t;

    typedef logic [`LEN_FUNC3-1:0] func3_t;

    // Register number.
    typedef logic [`LEN_REG_ADDR-1:0] reg_addr_t;
    typedef logic [`LEN_REG_ADDR-1:0] shamt_t; // Same width as a register number.

endpackage

// File: filelist.f
+incdir+common
common/exec_types_pkg.sv
common/exec_ctrl_pkg.sv
alu/divu_remu.sv
alu/alu.sv
source/exec_issue.sv
source/exec_unit.sv
verification/tb_exec_unit.sv

// File: source/exec_issue.sv
`include "exec_defines.svh"

module exec_issue (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      issue,
    input  exec_types_pkg::word_t     instr,
    input  exec_types_pkg::word_t     rs1_val,
    input  exec_types_pkg::word_t     rs2_val,
    input  logic                      accepted,
    input  logic                      done,
    input  exec_types_pkg::word_t     alu_rd,
    output logic                      issue_ready,
    output logic                      order,
    output exec_types_pkg::func3_t    func3,
    output logic                      mode_flag,
    output logic                      imm_flag,
    output logic                      extention_flag,
    output exec_types_pkg::word_t     op_a,
    output exec_types_pkg::word_t     op_b,
    output logic                      result_valid,
    output exec_types_pkg::word_t     result,
    output exec_types_pkg::reg_addr_t result_rd
);

    exec_ctrl_pkg::issue_state_t state_q;
    logic                        take;
    logic [6:0]                  opcode;
    exec_types_pkg::func3_t      dec_func3;
    logic                        dec_is_op;
    logic                        dec_is_imm;
    logic                        dec_is_shift;
    exec_types_pkg::word_t       imm_i;

    assign issue_ready = (state_q == exec_ctrl_pkg::issue_idle);
    assign take        = issue & issue_ready; // Strobes while busy are dropped.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= exec_ctrl_pkg::issue_idle;
        end else begin
            case (state_q)
                exec_ctrl_pkg::issue_idle: begin
                    if (take) begin
                        state_q <= exec_ctrl_pkg::issue_wait_accept;
                    end
                end
                exec_ctrl_pkg::issue_wait_accept: begin
                    if (accepted && done) begin
                        state_q <= exec_ctrl_pkg::issue_idle;
                    end else if (accepted) begin
                        state_q <= exec_ctrl_pkg::issue_wait_done;
                    end
                end
                exec_ctrl_pkg::issue_wait_done: begin
                    if (done) begin
                        state_q <= exec_ctrl_pkg::issue_idle;
                    end
                end
                default: state_q <= exec_ctrl_pkg::issue_idle;
            endcase
        end
    end

    assign order = (state_q == exec_ctrl_pkg::issue_wait_accept);

    // Field decode.
    assign opcode       = instr[6:0];
    assign dec_func3    = instr[14:12];
    assign dec_is_op    = (opcode == `OPCODE_OP);
    assign dec_is_imm   = (opcode == `OPCODE_OP_IMM);
    assign dec_is_shift = (dec_func3 == `FUNC3_SL) | (dec_func3 == `FUNC3_SR);
    assign imm_i        = {{(`LEN_WORD-12){instr[31]}}, instr[31:20]};

    always_ff @(posedge clk) begin
        if (take) begin
            func3          <= dec_func3;
            imm_flag       <= dec_is_imm;
            mode_flag      <= instr[30] & (dec_is_op | dec_is_shift);
            extention_flag <= instr[25] & dec_is_op;
            op_a           <= rs1_val;
            op_b           <= dec_is_imm ? imm_i : rs2_val;
            result_rd      <= instr[11:7];
        end
    end

    // Done only reaches us for our own order.
    assign result_valid = done & ~issue_ready;
    assign result       = alu_rd;

endmodule

// File: source/exec_unit.sv
`include "exec_defines.svh"

module exec_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      issue,
    input  exec_types_pkg::word_t     instr,
    input  exec_types_pkg::word_t     rs1_val,
    input  exec_types_pkg::word_t     rs2_val,
    output logic                      issue_ready,
    output logic                      result_valid,
    output exec_types_pkg::word_t     result,
    output exec_types_pkg::reg_addr_t result_rd
);

    logic                   order;
    logic                   accepted;
    logic                   done;
    exec_types_pkg::func3_t func3;
    logic                   mode_flag;
    logic                   imm_flag;
    logic                   extention_flag;
    exec_types_pkg::word_t  op_a;
    exec_types_pkg::word_t  op_b;
    exec_types_pkg::word_t  alu_rd;

    exec_issue u_exec_issue (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue          (issue),
        .instr          (instr),
        .rs1_val        (rs1_val),
        .rs2_val        (rs2_val),
        .accepted       (accepted),
        .done           (done),
        .alu_rd         (alu_rd),
        .issue_ready    (issue_ready),
        .order          (order),
        .func3          (func3),
        .mode_flag      (mode_flag),
        .imm_flag       (imm_flag),
        .extention_flag (extention_flag),
        .op_a           (op_a),
        .op_b           (op_b),
        .result_valid   (result_valid),
        .result         (result),
        .result_rd      (result_rd)
    );

    alu u_alu (
        .clk            (clk),
        .rst_n          (rst_n),
        .order          (order),
        .func3          (func3),
        .mode_flag      (mode_flag),
        .imm_flag       (imm_flag),
        .extention_flag (extention_flag),
        .rs1            (op_a),
        .rs2            (op_b),
        .accepted       (accepted),
        .done           (done),
        .rd             (alu_rd)
    );

endmodule

// File: verification/tb_exec_unit.sv
`include "exec_defines.svh"

module tb_exec_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_BASE    = 12; // Per base operation.
    localparam int N_IMM     = 10; // Per immediate operation.
    localparam int N_DIV     = 28;
    localparam int N_UNSUP   = 4;
    localparam int N_MIX     = 100;
    localparam int NUM_INSTR = 8 * N_BASE + 7 * N_IMM + N_DIV + 6 * N_UNSUP + N_MIX;
    localparam int DIV_LAT   = `DIV_STEPS + 2;

    logic                      clk;
    logic                      rst_n;
    logic                      issue;
    exec_types_pkg::word_t     instr;
    exec_types_pkg::word_t     rs1_val;
    exec_types_pkg::word_t     rs2_val;
    logic                      issue_ready;
    logic                      result_valid;
    exec_types_pkg::word_t     result;
    exec_types_pkg::reg_addr_t result_rd;

    integer seed;
    int     cycle;
    int     errors;
    int     checks;
    int     sent;
    int     tests;
    int     err_mark;
    int     sent_mark;

    exec_types_pkg::word_t     exp_result_q[$];
    exec_types_pkg::reg_addr_t exp_rd_q[$];
    int                        drive_cycle_q[$];
    int                        exp_lat_q[$];

    exec_unit u_exec_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .instr        (instr),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .issue_ready  (issue_ready),
        .result_valid (result_valid),
        .result       (result),
        .result_rd    (result_rd)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // RISC-V semantics for the supported subset.
    function automatic exec_types_pkg::word_t model_result(input exec_types_pkg::word_t ins,
                                                           input exec_types_pkg::word_t a,
                                                           input exec_types_pkg::word_t rs2);
        exec_types_pkg::word_t b;
        logic [4:0]            sh;
        logic                  is_op;
        is_op = (ins[6:0] == `OPCODE_OP);
        b     = is_op ? rs2 : {{20{ins[31]}}, ins[31:20]};
        sh    = b[4:0];
        if (is_op && ins[25]) begin
            case (ins[14:12])
                `FUNC3_DIVU: return (b == 0) ? '1 : a / b;
                `FUNC3_REMU: return (b == 0) ? a : a % b;
                default:     return '0; // MUL and signed DIV/REM.
            endcase
        end
        case (ins[14:12])
            `FUNC3_ADD: return (is_op && ins[30]) ? a - b : a + b;
            `FUNC3_SL:  return a << sh;
            `FUNC3_XOR: return a ^ b;
            `FUNC3_SR:  return ins[30] ? exec_types_pkg::word_t'($signed(a) >>> sh) : a >> sh;
            `FUNC3_OR:  return a | b;
            `FUNC3_AND: return a & b;
            default:    return '0;
        endcase
    endfunction

    function automatic bit is_divide(input exec_types_pkg::word_t ins);
        return (ins[6:0] == `OPCODE_OP) && ins[25] &&
               ((ins[14:12] == `FUNC3_DIVU) || (ins[14:12] == `FUNC3_REMU));
    endfunction

    function automatic exec_types_pkg::word_t r_type(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'($random(seed)), 5'($random(seed)), f3, 5'($random(seed)), `OPCODE_OP};
    endfunction

    function automatic exec_types_pkg::word_t i_type(input logic [11:0] imm, input logic [2:0] f3);
        return {imm, 5'($random(seed)), f3, 5'($random(seed)), `OPCODE_OP_IMM};
    endfunction

    function automatic exec_types_pkg::word_t base_instr(input int idx);
        case (idx)
            0:       return r_type(7'h00, 3'b000); // ADD
            1:       return r_type(7'h20, 3'b000); // SUB
            2:       return r_type(7'h00, 3'b001);
            3:       return r_type(7'h00, 3'b100);
            4:       return r_type(7'h00, 3'b101);
            5:       return r_type(7'h20, 3'b101); // SRA
            6:       return r_type(7'h00, 3'b110);
            default: return r_type(7'h00, 3'b111);
        endcase
    endfunction

    function automatic exec_types_pkg::word_t imm_instr(input int idx, input logic [11:0] imm);
        case (idx)
            0:       return i_type(imm, 3'b000);
            1:       return i_type({7'h00, imm[4:0]}, 3'b001); // SLLI
            2:       return i_type(imm, 3'b100);
            3:       return i_type({7'h00, imm[4:0]}, 3'b101); // SRLI
            4:       return i_type({7'h20, imm[4:0]}, 3'b101); // SRAI
            5:       return i_type(imm, 3'b110);
            default: return i_type(imm, 3'b111);
        endcase
    endfunction

    // Weighted mix of base, immediate, divide and unsupported M codes.
    function automatic exec_types_pkg::word_t random_instr();
        int pick;
        int sub;
        pick = $unsigned($random(seed)) % 100;
        sub  = $unsigned($random(seed)) % 8;
        if (pick < 45) return base_instr(sub);
        if (pick < 75) return imm_instr(sub % 7, 12'($random(seed)));
        if (pick < 90) return r_type(7'h01, sub[0] ? `FUNC3_REMU : `FUNC3_DIVU);
        return r_type(7'h01, (sub % 6 == 5) ? 3'b110 : 3'(sub % 6));
    endfunction

    task automatic send_instr(input exec_types_pkg::word_t ins,
                              input exec_types_pkg::word_t a,
                              input exec_types_pkg::word_t b);
        while (issue_ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        exp_result_q.push_back(model_result(ins, a, b));
        exp_rd_q.push_back(ins[11:7]);
        drive_cycle_q.push_back(cycle);
        exp_lat_q.push_back(is_divide(ins) ? DIV_LAT : 1);
        issue   = 1'b1;
        instr   = ins;
        rs1_val = a;
        rs2_val = b;
        sent++;
        @(posedge clk);
        #1;
        issue   = 1'b0;
        instr   = $random(seed); // Garbage while idle.
        rs1_val = $random(seed);
        rs2_val = $random(seed);
    endtask

    task automatic end_test(input string name);
        while (exp_result_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        tests++;
        $display("%-16s %0d instructions, %0d errors", name, sent - sent_mark, errors - err_mark);
        sent_mark = sent;
        err_mark  = errors;
    endtask

    task automatic check_result();
        exec_types_pkg::word_t     exp_res;
        exec_types_pkg::reg_addr_t exp_rd;
        int                        lat;
        int                        exp_lat;
        exp_res = exp_result_q.pop_front();
        exp_rd  = exp_rd_q.pop_front();
        lat     = cycle - drive_cycle_q.pop_front();
        exp_lat = exp_lat_q.pop_front();
        checks++;
        assert (result == exp_res) else begin
            $display("ERR %0t: result %h, expected %h", $time, result, exp_res);
            errors++;
        end
        assert (result_rd == exp_rd) else begin
            $display("ERR %0t: result_rd %0d, expected %0d", $time, result_rd, exp_rd);
            errors++;
        end
        assert (lat == exp_lat) else begin
            $display("ERR %0t: latency %0d cycles, expected %0d", $time, lat, exp_lat);
            errors++;
        end
    endtask

    // Outputs are sampled mid-cycle.
    always @(negedge clk) begin
        if (rst_n) begin
            if (result_valid) begin
                assert (exp_result_q.size() > 0) else begin
                    $display("Unexpected result_valid at %0t with nothing outstanding", $time);
                    errors++;
                end
                if (exp_result_q.size() > 0) check_result();
            end else if (exp_result_q.size() > 0 && cycle > drive_cycle_q[0]) begin
                assert (issue_ready == 1'b0) else begin
                    $display("ERR %0t: issue_ready high before the result arrived", $time);
                    errors++;
                end
            end
        end
    end

    initial begin
        repeat (NUM_INSTR * 40 + 100) @(posedge clk);
        $display("Watchdog expired at %0t, the DUT stopped returning results", $time);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        exec_types_pkg::word_t a;
        exec_types_pkg::word_t b;
        logic [11:0]           imm;
        seed    = 32'hf7e6;
        clk     = 1'b0;
        rst_n   = 1'b0;
        issue   = 1'b0;
        instr   = '0;
        rs1_val = '0;
        rs2_val = '0;
        cycle   = 0;
        errors  = 0;
        checks  = 0;
        sent    = 0;
        tests   = 0;
        err_mark  = 0;
        sent_mark = 0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        repeat (3) begin
            @(posedge clk);
            #1;
            checks++;
            assert (issue_ready === 1'b1 && result_valid === 1'b0) else begin
                $display("ERR %0t: ready %b valid %b after reset", $time, issue_ready, result_valid);
                errors++;
            end
        end
        end_test("reset_state");

        for (int op = 0; op < 8; op++) begin
            for (int k = 0; k < N_BASE; k++) begin
                send_instr(base_instr(op), $random(seed), $random(seed));
            end
        end
        end_test("base_ops");

        for (int op = 0; op < 7; op++) begin
            for (int k = 0; k < N_IMM; k++) begin
                imm = $random(seed);
                imm[10] = k[0]; // Sets instruction bit 30 on every other ADDI.
                send_instr(imm_instr(op, imm), $random(seed), $random(seed));
            end
        end
        end_test("immediate_ops");

        for (int k = 0; k < N_DIV; k++) begin
            a = $random(seed);
            b = $random(seed);
            case (k % 4)
                0: b = '0;
                1: begin
                    a = a & 32'h0000_ffff;
                    b = b | 32'h0001_0000; // Divisor above dividend.
                end
                2: b = b & 32'h0000_00ff;
                default: ;
            endcase
            send_instr(r_type(7'h01, ((k >> 2) & 1) ? `FUNC3_REMU : `FUNC3_DIVU), a, b);
        end
        end_test("division");

        for (int f = 0; f < 6; f++) begin
            for (int k = 0; k < N_UNSUP; k++) begin
                send_instr(r_type(7'h01, (f == 5) ? 3'b110 : 3'(f)), $random(seed), $random(seed));
            end
        end
        end_test("unsupported_m");

        for (int k = 0; k < N_MIX; k++) begin
            send_instr(random_instr(), $random(seed), $random(seed));
        end
        end_test("back_to_back");

        $display("Summary: %0d tests, %0d instructions, %0d checks, %0d errors",
                 tests, sent, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
